// File: project.f
source/cpu_pkg.sv
source/pipe_if.sv
source/pc_unit.sv
source/reg_file.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/cpu_top.sv
tb/cpu_checker.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_top -f project.f -o tb_top_sim > sim.log 2>&1 \
    && ./obj_dir/tb_top_sim >> sim.log 2>&1

cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// File: source/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    // ALU operations of the RV32I subset
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // Major opcodes kept in the subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    localparam word_t      RESET_PC   = 32'h0000_0000;
    localparam word_t      PC_STEP    = 32'd4;
    localparam logic [3:0] DM_WE_WORD = 4'b1111;

endpackage

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic            clk,
    input  logic            arst_n,
    output cpu_pkg::word_t  im_addr,
    input  cpu_pkg::instr_t im_instr,
    output cpu_pkg::word_t  dm_addr,
    output cpu_pkg::word_t  dm_wdata,
    output logic [3:0]      dm_we,
    output logic            dm_oe,
    input  cpu_pkg::word_t  dm_rdata
);
    import cpu_pkg::*;

    logic       stall;
    logic       flush_ifid;
    logic       bubble_idex;
    logic       redirect;
    word_t      redirect_pc;
    reg_addr_t  id_rs1;
    reg_addr_t  id_rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    logic [1:0] fwd_a_sel;
    logic [1:0] fwd_b_sel;

    id_ex_if u_idex_if ();
    fwd_if   u_fwd_if ();

    pc_unit u_pc_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (im_addr)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (im_instr),
        .pc          (im_addr),
        .stall       (stall),
        .flush_ifid  (flush_ifid),
        .bubble_idex (bubble_idex),
        .rs1_addr    (id_rs1),
        .rs2_addr    (id_rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .idex        (u_idex_if.producer)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (id_rs1),
        .rs2_addr (id_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd      (u_fwd_if.reader)
    );

    hazard_unit u_hazard_unit (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .idex        (u_idex_if.monitor),
        .fwd         (u_fwd_if.reader),
        .redirect    (redirect),
        .stall       (stall),
        .flush_ifid  (flush_ifid),
        .bubble_idex (bubble_idex),
        .fwd_a_sel   (fwd_a_sel),
        .fwd_b_sel   (fwd_b_sel)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .idex        (u_idex_if.consumer),
        .fwd_a_sel   (fwd_a_sel),
        .fwd_b_sel   (fwd_b_sel),
        .fwd         (u_fwd_if.ex_side),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .dm_addr     (dm_addr),
        .dm_wdata    (dm_wdata),
        .dm_we       (dm_we),
        .dm_oe       (dm_oe)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .dm_rdata      (dm_rdata),
        .fwd           (u_fwd_if.wb_side),
        .mem_result    (u_fwd_if.mem_result),
        .mem_rd        (u_fwd_if.mem_rd),
        .mem_reg_write (u_fwd_if.mem_reg_write),
        .mem_is_load   (dm_oe)
    );

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::instr_t    instr,
    input  cpu_pkg::word_t     pc,
    input  logic               stall,
    input  logic               flush_ifid,
    input  logic               bubble_idex,
    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::word_t     rs1_data,
    input  cpu_pkg::word_t     rs2_data,
    id_ex_if.producer          idex
);
    import cpu_pkg::*;

    instr_t     ifid_instr;
    word_t      ifid_pc;
    logic       ifid_valid;

    opcode_e    opcode;
    alu_op_e    alu_op;
    word_t      imm;
    logic       alu_src_imm;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       is_branch;
    logic       is_jump;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       kill;

    function automatic alu_op_e funct_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // IF/ID register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifid_valid <= 1'b0;
        end else if (flush_ifid) begin
            ifid_valid <= 1'b0;
        end else if (!stall) begin
            ifid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_instr <= instr;
            ifid_pc    <= pc;
        end
    end

    assign opcode = opcode_e'(ifid_instr[6:0]);

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b0;
        // I-type unless overridden
        imm         = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
        case (opcode)
            OPC_OP: begin
                alu_op    = funct_op(ifid_instr[14:12], ifid_instr[30]);
                reg_write = 1'b1;
                uses_rs2  = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op      = funct_op(ifid_instr[14:12], 1'b0);
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
            end
            OPC_STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                uses_rs2    = 1'b1;
                imm         = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                uses_rs2  = 1'b1;
                imm       = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
                             ifid_instr[30:25], ifid_instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                alu_op    = ALU_PASS_B;
                reg_write = 1'b1;
                is_jump   = 1'b1;
                uses_rs1  = 1'b0;
                imm       = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
                             ifid_instr[20], ifid_instr[30:21], 1'b0};
            end
            default: begin
                uses_rs1 = 1'b0;
            end
        endcase
    end

    // Unused source fields read x0 so they never look like hazards
    assign rs1_addr = uses_rs1 ? ifid_instr[19:15] : '0;
    assign rs2_addr = uses_rs2 ? ifid_instr[24:20] : '0;

    assign kill = !ifid_valid || bubble_idex || flush_ifid;

    // ID/EX control bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex.mem_read  <= 1'b0;
            idex.mem_write <= 1'b0;
            idex.reg_write <= 1'b0;
            idex.is_branch <= 1'b0;
            idex.is_jump   <= 1'b0;
        end else begin
            idex.mem_read  <= mem_read && !kill;
            idex.mem_write <= mem_write && !kill;
            idex.reg_write <= reg_write && !kill;
            idex.is_branch <= is_branch && !kill;
            idex.is_jump   <= is_jump && !kill;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        idex.rs1_val     <= rs1_data;
        idex.rs2_val     <= rs2_data;
        idex.rs1         <= rs1_addr;
        idex.rs2         <= rs2_addr;
        idex.rd          <= ifid_instr[11:7];
        idex.imm         <= imm;
        idex.pc          <= ifid_pc;
        idex.alu_op      <= alu_op;
        idex.alu_src_imm <= alu_src_imm;
    end

    // Raw opcode bits outside the subset must leave ID/EX without write enables
    a_unknown_op_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        ifid_valid && !(ifid_instr[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD,
                                                OPC_STORE, OPC_BRANCH, OPC_JAL})
        |=> !idex.reg_write && !idex.mem_write && !idex.mem_read)
        else $error("undecoded opcode reached execute with write enables");

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic           clk,
    input  logic           arst_n,
    id_ex_if.consumer      idex,
    input  logic [1:0]     fwd_a_sel,
    input  logic [1:0]     fwd_b_sel,
    fwd_if.ex_side         fwd,
    output logic           redirect,
    output cpu_pkg::word_t redirect_pc,
    output cpu_pkg::word_t dm_addr,
    output cpu_pkg::word_t dm_wdata,
    output logic [3:0]     dm_we,
    output logic           dm_oe
);
    import cpu_pkg::*;

    word_t     op_a;
    word_t     rs2_fwd;
    word_t     op_b;
    word_t     alu_res;
    word_t     exmem_result;
    word_t     exmem_wdata;
    reg_addr_t exmem_rd;
    logic      exmem_reg_write;
    logic      exmem_mem_read;
    logic      exmem_mem_write;

    function automatic word_t pick(input logic [1:0] sel, input word_t own,
                                   input word_t mem_val, input word_t wb_val);
        case (sel)
            2'b01:   return mem_val;
            2'b10:   return wb_val;
            default: return own;
        endcase
    endfunction

    assign op_a    = pick(fwd_a_sel, idex.rs1_val, exmem_result, fwd.wb_data);
    assign rs2_fwd = pick(fwd_b_sel, idex.rs2_val, exmem_result, fwd.wb_data);

    // jal links pc+4 through the B operand
    assign op_b = idex.is_jump     ? idex.pc + PC_STEP :
                  idex.alu_src_imm ? idex.imm : rs2_fwd;

    always_comb begin
        case (idex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // Only beq survives, so taken means equal
    assign redirect    = idex.is_jump || (idex.is_branch && op_a == rs2_fwd);
    assign redirect_pc = idex.pc + idex.imm;

    // EX/MEM register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exmem_reg_write <= 1'b0;
            exmem_mem_read  <= 1'b0;
            exmem_mem_write <= 1'b0;
        end else begin
            exmem_reg_write <= idex.reg_write;
            exmem_mem_read  <= idex.mem_read;
            exmem_mem_write <= idex.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        exmem_result <= alu_res;
        exmem_wdata  <= rs2_fwd;
        exmem_rd     <= idex.rd;
    end

    assign dm_addr  = exmem_result;
    assign dm_wdata = exmem_wdata;
    assign dm_we    = exmem_mem_write ? DM_WE_WORD : 4'b0000;
    assign dm_oe    = exmem_mem_read;

    assign fwd.mem_rd        = exmem_rd;
    assign fwd.mem_reg_write = exmem_reg_write;
    assign fwd.mem_result    = exmem_result;

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t id_rs1,
    input  cpu_pkg::reg_addr_t id_rs2,
    id_ex_if.monitor           idex,
    fwd_if.reader              fwd,
    input  logic               redirect,
    output logic               stall,
    output logic               flush_ifid,
    output logic               bubble_idex,
    output logic [1:0]         fwd_a_sel,
    output logic [1:0]         fwd_b_sel
);
    import cpu_pkg::*;

    logic load_use;

    // 01 takes MEM, 10 takes WB, MEM is younger so it wins
    function automatic logic [1:0] pick_src(input reg_addr_t rs,
                                            input reg_addr_t mem_rd, input logic mem_we,
                                            input reg_addr_t wb_rd, input logic wb_we);
        if (rs == '0) begin
            return 2'b00;
        end
        if (mem_we && mem_rd == rs) begin
            return 2'b01;
        end
        if (wb_we && wb_rd == rs) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    assign load_use = idex.mem_read && (idex.rd != '0) &&
                      (idex.rd == id_rs1 || idex.rd == id_rs2);

    assign stall       = load_use && !redirect;
    assign flush_ifid  = redirect;
    assign bubble_idex = load_use || redirect;

    assign fwd_a_sel = pick_src(idex.rs1, fwd.mem_rd, fwd.mem_reg_write,
                                fwd.wb_rd, fwd.wb_reg_write);
    assign fwd_b_sel = pick_src(idex.rs2, fwd.mem_rd, fwd.mem_reg_write,
                                fwd.wb_rd, fwd.wb_reg_write);

    // A load in execute can never also be the redirecting instruction
    always_comb begin
        a_no_stall_redirect: assert (!(load_use && redirect))
            else $error("load-use hold and redirect requested together");
    end

endmodule

// File: source/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     dm_rdata,
    fwd_if.wb_side             fwd,
    input  cpu_pkg::word_t     mem_result,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               mem_reg_write,
    input  logic               mem_is_load
);
    import cpu_pkg::*;

    logic      reg_write_q;
    reg_addr_t rd_q;
    word_t     data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_write_q <= 1'b0;
        end else begin
            reg_write_q <= mem_reg_write;
        end
    end

    // Writeback select happens before the register
    always_ff @(posedge clk) begin
        rd_q   <= mem_rd;
        data_q <= mem_is_load ? dm_rdata : mem_result;
    end

    assign fwd.wb_reg_write = reg_write_q;
    assign fwd.wb_rd        = rd_q;
    assign fwd.wb_data      = data_q;

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    output cpu_pkg::word_t pc
);
    import cpu_pkg::*;

    // Redirect from execute beats the load-use hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + PC_STEP;
        end
    end

    // Branch and jump targets must keep fetch word-aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("fetch address %h is not word-aligned", pc);

endmodule

// File: source/pipe_if.sv
`timescale 1ns/1ps

// Decoded instruction leaving the ID/EX register
interface id_ex_if;
    import cpu_pkg::*;

    word_t     rs1_val;
    word_t     rs2_val;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     pc;
    alu_op_e   alu_op;
    logic      alu_src_imm;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      is_branch;
    logic      is_jump;

    modport producer (
        output rs1_val, rs2_val, rs1, rs2, rd, imm, pc,
        output alu_op, alu_src_imm, mem_read, mem_write, reg_write, is_branch, is_jump
    );

    modport consumer (
        input rs1_val, rs2_val, rs1, rs2, rd, imm, pc,
        input alu_op, alu_src_imm, mem_read, mem_write, reg_write, is_branch, is_jump
    );

    modport monitor (input rd, mem_read, rs1, rs2);
endinterface

// Results still in flight in MEM and WB
interface fwd_if;
    import cpu_pkg::*;

    reg_addr_t mem_rd;
    logic      mem_reg_write;
    word_t     mem_result;
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    word_t     wb_data;

    modport ex_side (
        output mem_rd, mem_reg_write, mem_result,
        input  wb_rd, wb_reg_write, wb_data
    );
    modport wb_side (output wb_rd, wb_reg_write, wb_data);
    modport reader (input mem_rd, mem_reg_write, mem_result, wb_rd, wb_reg_write, wb_data);
endinterface

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,
    fwd_if.reader              fwd
);
    import cpu_pkg::*;

    word_t regs [32];
    logic  wr_en;

    // x0 is never written
    assign wr_en = fwd.wb_reg_write && (fwd.wb_rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[fwd.wb_rd] <= fwd.wb_data;
        end
    end

    // Same-cycle write shows through to decode
    assign rs1_data = (wr_en && fwd.wb_rd == rs1_addr) ? fwd.wb_data : regs[rs1_addr];
    assign rs2_data = (wr_en && fwd.wb_rd == rs2_addr) ? fwd.wb_data : regs[rs2_addr];

endmodule

// File: tb/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input logic           clk,
    input logic           arst_n,
    input cpu_pkg::word_t im_addr,
    input cpu_pkg::word_t dm_addr,
    input cpu_pkg::word_t dm_wdata,
    input logic [3:0]     dm_we,
    input logic           dm_oe
);
    import cpu_pkg::*;

    word_t exp_addr [$];
    word_t exp_data [$];
    string exp_name [$];
    int    passes = 0;
    int    errors = 0;
    int    loads_expected = 0;
    int    loads_seen = 0;
    int    cycles_out_of_reset = 0;
    logic  reset_ok = 1'b1;
    word_t prev_im_addr = '0;

    task automatic expect_store(input word_t addr, input word_t data, input string name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_name.push_back(name);
    endtask

    task automatic expect_load_hold();
        loads_expected++;
    endtask

    task automatic check_reset_state();
        if (reset_ok && (im_addr != RESET_PC || dm_we != 4'b0000 || dm_oe)) begin
            reset_ok = 1'b0;
            errors++;
            $display("CHECK FAILED reset: expected im_addr %h dm_we 0 dm_oe 0, %s %h %h %b",
                     RESET_PC, "actual im_addr/dm_we/dm_oe", im_addr, dm_we, dm_oe);
        end
    endtask

    // In-order match against the store table
    task automatic check_store();
        word_t addr;
        word_t data;
        string name;
        if (exp_name.size() == 0) begin
            errors++;
            $display("Unexpected store of %h to address %h after the last expected store",
                     dm_wdata, dm_addr);
        end else begin
            addr = exp_addr.pop_front();
            data = exp_data.pop_front();
            name = exp_name.pop_front();
            if (dm_addr == addr && dm_wdata == data && dm_we == DM_WE_WORD) begin
                passes++;
                $display("PASS %s", name);
            end else begin
                errors++;
                $display("CHECK FAILED %s: expected [%h]=%h we %b, actual [%h]=%h we %b",
                         name, addr, data, DM_WE_WORD, dm_addr, dm_wdata, dm_we);
            end
        end
    endtask

    // Load in MEM means the dependent instruction was held one cycle
    task automatic check_load_hold();
        loads_seen++;
        if (im_addr == prev_im_addr) begin
            passes++;
            $display("PASS load_use_hold");
        end else begin
            errors++;
            $display("CHECK FAILED load_use_hold: expected im_addr %h, actual %h",
                     prev_im_addr, im_addr);
        end
    endtask

    task automatic close_out();
        while (exp_name.size() > 0) begin
            errors++;
            $display("Missing store: test %s never wrote address %h",
                     exp_name[0], exp_addr[0]);
            exp_name.delete(0);
            exp_addr.delete(0);
            exp_data.delete(0);
        end
        if (loads_seen != loads_expected) begin
            errors++;
            $display("Saw %0d loads reach the memory stage, but the program issues %0d",
                     loads_seen, loads_expected);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n !== 1'b1) begin
            cycles_out_of_reset = 0;
            check_reset_state();
        end else begin
            cycles_out_of_reset++;
            if (cycles_out_of_reset == 1) begin
                check_reset_state();
                if (reset_ok) begin
                    passes++;
                    $display("PASS reset");
                end
            end
            if (dm_we != 4'b0000) begin
                check_store();
            end
            if (dm_oe) begin
                check_load_hold();
            end
        end
        prev_im_addr = im_addr;
    end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import cpu_pkg::*;

    logic       clk;
    logic       arst_n;
    word_t      im_addr;
    instr_t     im_instr;
    word_t      dm_addr;
    word_t      dm_wdata;
    logic [3:0] dm_we;
    logic       dm_oe;
    word_t      dm_rdata;

    instr_t imem [64];
    word_t  dmem [256];

    // Program table and expected store table
    instr_t prog_instr [$];
    string  prog_name [$];
    word_t  st_addr [$];
    word_t  st_data [$];
    string  st_name [$];
    word_t  jal_link;

    cpu_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .im_addr  (im_addr),
        .im_instr (im_instr),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .dm_oe    (dm_oe),
        .dm_rdata (dm_rdata)
    );

    cpu_checker u_chk (
        .clk      (clk),
        .arst_n   (arst_n),
        .im_addr  (im_addr),
        .dm_addr  (dm_addr),
        .dm_wdata (dm_wdata),
        .dm_we    (dm_we),
        .dm_oe    (dm_oe)
    );

    // Both memories answer in the same cycle
    assign im_instr = imem[im_addr[7:2]];
    assign dm_rdata = dmem[dm_addr[9:2]];

    always @(posedge clk) begin
        if (dm_we != 4'b0000) begin
            dmem[dm_addr[9:2]] <= dm_wdata;
        end
    end

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(input logic [4:0] rs2, input logic [4:0] rs1, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:5], rs2, rs1, 3'b010, v[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                       input int imm);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2, rs1, 3'b000, v[4:1], v[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_jal(input logic [4:0] rd, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_instr(input instr_t instr, input string name);
        prog_instr.push_back(instr);
        prog_name.push_back(name);
    endtask

    task automatic add_store(input word_t addr, input word_t data, input string name);
        st_addr.push_back(addr);
        st_data.push_back(data);
        st_name.push_back(name);
    endtask

    task automatic build_program();
        add_instr(enc_i(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 100), "setup");
        add_instr(enc_i(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, -7), "setup");
        add_instr(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), "add");
        add_instr(enc_s(5'd3, 5'd0, 'h100), "add");
        add_instr(enc_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), "sub");
        add_instr(enc_s(5'd4, 5'd0, 'h104), "sub");
        add_instr(enc_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), "and");
        add_instr(enc_s(5'd5, 5'd0, 'h108), "and");
        add_instr(enc_r(7'h00, 3'b110, 5'd6, 5'd1, 5'd2), "or");
        add_instr(enc_s(5'd6, 5'd0, 'h10C), "or");
        add_instr(enc_r(7'h00, 3'b100, 5'd7, 5'd1, 5'd2), "xor");
        add_instr(enc_s(5'd7, 5'd0, 'h110), "xor");
        add_instr(enc_r(7'h00, 3'b010, 5'd8, 5'd2, 5'd1), "slt");
        add_instr(enc_s(5'd8, 5'd0, 'h114), "slt");
        add_instr(enc_i(OPC_OP_IMM, 3'b000, 5'd9, 5'd1, 23), "addi");
        add_instr(enc_s(5'd9, 5'd0, 'h118), "addi");
        // Back-to-back chain through x10
        add_instr(enc_i(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 5), "fwd_chain");
        add_instr(enc_r(7'h00, 3'b000, 5'd10, 5'd10, 5'd10), "fwd_chain");
        add_instr(enc_r(7'h00, 3'b000, 5'd10, 5'd10, 5'd10), "fwd_chain");
        add_instr(enc_r(7'h20, 3'b000, 5'd11, 5'd10, 5'd1), "fwd_chain");
        add_instr(enc_s(5'd11, 5'd0, 'h11C), "fwd_chain");
        add_instr(enc_i(OPC_LOAD, 3'b010, 5'd12, 5'd0, 'h40), "load_use");
        add_instr(enc_r(7'h00, 3'b000, 5'd13, 5'd12, 5'd1), "load_use");
        add_instr(enc_s(5'd13, 5'd0, 'h120), "load_use");
        add_instr(enc_i(OPC_LOAD, 3'b010, 5'd14, 5'd0, 'h44), "load_store");
        add_instr(enc_s(5'd14, 5'd0, 'h124), "load_store");
        add_instr(enc_beq(5'd1, 5'd1, 12), "beq_taken");
        add_instr(enc_s(5'd1, 5'd0, 'h1F0), "beq_taken");
        add_instr(enc_s(5'd1, 5'd0, 'h1F4), "beq_taken");
        add_instr(enc_beq(5'd1, 5'd2, 8), "beq_not_taken");
        add_instr(enc_s(5'd2, 5'd0, 'h128), "beq_not_taken");
        jal_link = word_t'(prog_instr.size() * 4) + 32'd4;
        add_instr(enc_jal(5'd15, 12), "jal_link");
        add_instr(enc_s(5'd1, 5'd0, 'h1F8), "jal_link");
        add_instr(enc_s(5'd1, 5'd0, 'h1FC), "jal_link");
        add_instr(enc_s(5'd15, 5'd0, 'h12C), "jal_link");
        add_instr(enc_i(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 55), "x0_write");
        add_instr(enc_s(5'd0, 5'd0, 'h130), "x0_write");
        add_instr(enc_jal(5'd0, 0), "halt");
    endtask

    // Expected stores from the ISA rules and the seeded data words
    task automatic build_expected();
        word_t a;
        word_t b;
        word_t c;
        a = 32'd100;
        b = word_t'(-7);
        c = 32'd5;
        c = c + c;
        c = c + c;
        add_store(32'h100, a + b, "add");
        add_store(32'h104, a - b, "sub");
        add_store(32'h108, a & b, "and");
        add_store(32'h10C, a | b, "or");
        add_store(32'h110, a ^ b, "xor");
        add_store(32'h114, {31'b0, $signed(b) < $signed(a)}, "slt");
        add_store(32'h118, a + 32'd23, "addi");
        add_store(32'h11C, c - a, "fwd_chain");
        add_store(32'h120, dmem[16] + a, "load_use");
        add_store(32'h124, dmem[17], "load_store");
        add_store(32'h128, b, "beq_not_taken");
        add_store(32'h12C, jal_link, "jal_link");
        add_store(32'h130, 32'd0, "x0_write");
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        word_t rnd;
        word_t halt_pc;
        arst_n = 1'b0;
        build_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = enc_i(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 0);
        end
        for (int i = 0; i < prog_instr.size(); i++) begin
            imem[i] = prog_instr[i];
            if (prog_instr[i][6:0] == OPC_LOAD) begin
                u_chk.expect_load_hold();
            end
        end
        rnd = 32'd48937;
        for (int i = 0; i < 256; i++) begin
            rnd = xorshift32(rnd);
            dmem[i] = rnd;
        end
        build_expected();
        for (int i = 0; i < st_name.size(); i++) begin
            u_chk.expect_store(st_addr[i], st_data[i], st_name[i]);
        end
        halt_pc = word_t'((prog_instr.size() - 1) * 4);

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        while (im_addr != halt_pc) begin
            @(negedge clk);
        end
        // Stores ahead of the halt jump leave the pipeline
        repeat (4) @(negedge clk);
        u_chk.close_out();

        $display("Tests: %0d passed, %0d failed", u_chk.passes, u_chk.errors);
        if (u_chk.errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        int limit;
        @(posedge arst_n);
        limit = prog_instr.size() * 4 + 50;
        repeat (limit) @(posedge clk);
        if (im_addr[31:2] < prog_name.size()) begin
            $display("Timeout after %0d cycles in test %s, fetch address %h",
                     limit, prog_name[im_addr[31:2]], im_addr);
        end else begin
            $display("Timeout: halt loop not reached within %0d cycles, last fetch %h",
                     limit, im_addr);
        end
        $display("Verification failed");
        $finish;
    end

endmodule
